// File: sim.f
verilog/qam_duc_pkg.sv
verilog/cfg_regs.sv
verilog/sym_intake.sv
verilog/qam_mapper.sv
verilog/mixer_stage.sv
verilog/dac_packer.sv
verilog/qam_duc_top.sv
tests/tb_qam_duc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_qam_duc
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_qam_duc.sv
// Testbench for the eight-channel 16-QAM baseband modulator.
// Drives host writes and four-phase symbols, checks DAC pairs against a reference model.

`timescale 1ns/100ps
`default_nettype none

module tb_qam_duc
    import qam_duc_pkg::*;
();

    localparam int NUM_SYMS   = 229;
    localparam int NUM_WRITES = 30;
    localparam int LIMIT_CYC  = NUM_SYMS * 12 + NUM_WRITES * 16 + 500;

    logic              clk_341m;
    logic              rst_duc;
    logic [ADDR_W-1:0] cfg_addr;
    logic [DATA_W-1:0] cfg_data;
    logic              cfg_write;
    logic              sym_req;
    sym_beat_t         sym_in;
    logic              sym_ack;
    dac_pair_t         dac_out;
    logic              dac_valid;

    int          seed;
    string       cur_test;
    iq_t         exp_q[$];
    logic [7:0]  ena_ref;
    logic [7:0]  gain_ref [NUM_CH];
    logic [9:0]  freq_ref [NUM_CH];
    logic [9:0]  phase_ref [NUM_CH];

    qam_duc_top qam_duc_top_i (
        .clk_341m  (clk_341m),
        .rst_duc   (rst_duc),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg_write (cfg_write),
        .sym_req   (sym_req),
        .sym_in    (sym_in),
        .sym_ack   (sym_ack),
        .dac_out   (dac_out),
        .dac_valid (dac_valid)
    );

    initial
    begin
        clk_341m = 1'b0;
        forever #20 clk_341m = ~clk_341m;
    end

    // Sign from the high bit, magnitude from the low bit.
    function automatic int level_of(input logic [1:0] bits);
        return (bits[1] ? 1 : -1) * (bits[0] ? 1 : 3);
    endfunction

    function automatic iq_t ref_sample(input logic [3:0] sym, input int gain,
                                       input logic [1:0] quad);
        int  li;
        int  lq;
        int  ri;
        int  rq;
        iq_t r;
        li = level_of(sym[3:2]) * gain;
        lq = level_of(sym[1:0]) * gain;
        case (quad)
            2'd0:
            begin
                ri = li;
                rq = lq;
            end
            2'd1:
            begin
                ri = -lq;
                rq = li;
            end
            2'd2:
            begin
                ri = -li;
                rq = -lq;
            end
            default:
            begin
                ri = lq;
                rq = -li;
            end
        endcase
        r.i = 14'(ri);
        r.q = 14'(rq);
        return r;
    endfunction

    task automatic check_val(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     cur_test, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Stopped at first error.");
        end
    endtask

    task automatic host_write(input logic [11:0] addr, input logic [15:0] data);
        @(posedge clk_341m);
        #2;
        cfg_addr  = addr;
        cfg_data  = data;
        cfg_write = 1'b1;
        repeat (4) @(posedge clk_341m);
        #2;
        cfg_write = 1'b0;
        repeat (8) @(posedge clk_341m);
        if (addr[11:4] == 8'h41 && addr[3:0] < 4'd8)
            gain_ref[addr[2:0]] = data[7:0];
        else if (addr[11:4] == 8'h52 && addr[3:0] < 4'd8)
            freq_ref[addr[2:0]] = data[9:0];
        else if (addr == 12'h511)
            ena_ref = data[7:0];
    endtask

    task automatic send_symbol(input logic [2:0] ch, input logic [3:0] sym);
        if (ena_ref[ch])
        begin
            exp_q.push_back(ref_sample(sym, int'(gain_ref[ch]), phase_ref[ch][9:8]));
            phase_ref[ch] = phase_ref[ch] + freq_ref[ch];
        end
        @(posedge clk_341m);
        #2;
        sym_in.ch  = ch;
        sym_in.sym = sym;
        sym_req    = 1'b1;
        @(negedge clk_341m);
        while (!sym_ack)
            @(negedge clk_341m);
        @(posedge clk_341m);
        #2;
        sym_req = 1'b0;
        @(negedge clk_341m);
        while (sym_ack)
            @(negedge clk_341m);
    endtask

    task automatic send_random(input int count);
        for (int n = 0; n < count; n++)
            send_symbol(3'($random(seed)), 4'($random(seed)));
    endtask

    // An odd sample count leaves slot a waiting, so one more enabled symbol closes it.
    task automatic close_pair();
        int ch;
        ch = 0;
        if (exp_q.size() % 2 == 1)
        begin
            while (!ena_ref[ch])
                ch++;
            send_symbol(3'(ch), 4'($random(seed)));
        end
    endtask

    initial
    begin
        iq_t exp_a;
        iq_t exp_b;
        forever
        begin
            @(negedge clk_341m);
            if (dac_valid)
            begin
                if (exp_q.size() < 2)
                begin
                    $display("Unexpected DAC output in %s with %0d samples expected.",
                             cur_test, exp_q.size());
                    $display("Test failed");
                    $fatal(1, "Stopped at first error.");
                end
                else
                begin
                    exp_a = exp_q.pop_front();
                    exp_b = exp_q.pop_front();
                    check_val("slot a", 64'(exp_a), 64'(dac_out.a));
                    check_val("slot b", 64'(exp_b), 64'(dac_out.b));
                end
            end
        end
    end

    initial
    begin
        #(LIMIT_CYC * 40);
        $display("Timeout: the run did not finish within %0d cycles.", LIMIT_CYC);
        $display("Test failed");
        $fatal(1, "Stopped on timeout.");
    end

    initial
    begin
        seed      = 32'h838b_7bb6;
        rst_duc   = 1'b1;
        cfg_addr  = '0;
        cfg_data  = '0;
        cfg_write = 1'b0;
        sym_req   = 1'b0;
        sym_in    = '0;
        ena_ref   = '0;
        for (int c = 0; c < NUM_CH; c++)
        begin
            gain_ref[c]  = '0;
            freq_ref[c]  = '0;
            phase_ref[c] = '0;
        end
        repeat (16) @(posedge clk_341m);
        #2;
        rst_duc = 1'b0;

        cur_test = "reset_state";
        @(negedge clk_341m);
        check_val("sym_ack", 64'(0), 64'(sym_ack));
        check_val("dac_valid", 64'(0), 64'(dac_valid));
        send_random(8);
        repeat (10) @(posedge clk_341m);

        cur_test = "mapping_gain";
        host_write(12'h511, 16'h0001);
        host_write(12'h410, 16'h0001);
        host_write(12'h520, 16'h0000);
        for (int s = 0; s < 16; s++)
            send_symbol(3'd0, 4'(s));

        cur_test = "channel_gain";
        host_write(12'h511, 16'h00ff);
        for (int c = 0; c < NUM_CH; c++)
            host_write(12'h410 + 12'(c), 16'(($random(seed) & 8'hfe) | 1));
        send_random(32);
        close_pair();

        cur_test = "quadrant_rotation";
        host_write(12'h511, 16'h0006);
        host_write(12'h521, 16'd256);
        host_write(12'h522, 16'd64);
        for (int n = 0; n < 8; n++)
            send_symbol(3'd1, 4'($random(seed)));
        for (int n = 0; n < 16; n++)
            send_symbol(3'd2, 4'($random(seed)));

        cur_test = "enable_mask";
        host_write(12'h511, 16'h0055);
        send_random(24);
        close_pair();

        cur_test = "mixed_random";
        for (int blk = 0; blk < 6; blk++)
        begin
            case ($unsigned($random(seed)) % 3)
                0: host_write(12'h410 + 12'($unsigned($random(seed)) % 8),
                              16'($random(seed) & 16'h00ff));
                1: host_write(12'h520 + 12'($unsigned($random(seed)) % 8),
                              16'($random(seed) & 16'h03ff));
                default: host_write(12'h511, 16'(($random(seed) & 16'h00ff) | 1));
            endcase
            send_random(20);
        end
        close_pair();

        // The last pair leaves the packer three cycles after its beat.
        repeat (10) @(posedge clk_341m);
        if (exp_q.size() == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Expected samples were left without output.");
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/qam_duc_top.sv
// Eight-channel 16-QAM baseband modulator top level.
// Host register file feeding a shared intake, mapper, mixer and DAC packer pipeline.

`timescale 1ns/100ps
`default_nettype none

module qam_duc_top
    import qam_duc_pkg::*;
(
    input  wire logic              clk_341m,
    input  wire logic              rst_duc,
    input  wire logic [ADDR_W-1:0] cfg_addr,
    input  wire logic [DATA_W-1:0] cfg_data,
    input  wire logic              cfg_write,
    input  wire logic              sym_req,
    input  sym_beat_t              sym_in,
    output logic                   sym_ack,
    output dac_pair_t              dac_out,
    output logic                   dac_valid
);

    cfg_t       cfg;
    sym_beat_t  beat;
    logic       beat_valid;
    samp_beat_t samp;
    logic       samp_valid;
    samp_beat_t rot;
    logic       rot_valid;

    cfg_regs cfg_regs_i (
        .clk_341m  (clk_341m),
        .rst_duc   (rst_duc),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg_write (cfg_write),
        .cfg       (cfg)
    );

    sym_intake sym_intake_i (
        .clk_341m   (clk_341m),
        .rst_duc    (rst_duc),
        .sym_req    (sym_req),
        .sym_in     (sym_in),
        .sym_ack    (sym_ack),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    qam_mapper qam_mapper_i (
        .clk_341m   (clk_341m),
        .rst_duc    (rst_duc),
        .beat       (beat),
        .beat_valid (beat_valid),
        .cfg        (cfg),
        .samp       (samp),
        .samp_valid (samp_valid)
    );

    mixer_stage mixer_stage_i (
        .clk_341m   (clk_341m),
        .rst_duc    (rst_duc),
        .samp       (samp),
        .samp_valid (samp_valid),
        .cfg        (cfg),
        .rot        (rot),
        .rot_valid  (rot_valid)
    );

    dac_packer dac_packer_i (
        .clk_341m  (clk_341m),
        .rst_duc   (rst_duc),
        .rot       (rot),
        .rot_valid (rot_valid),
        .dac_out   (dac_out),
        .dac_valid (dac_valid)
    );

endmodule

`default_nettype wire

// File: verilog/dac_packer.sv
// Packs consecutive mixer samples into DAC word pairs.
// A pair is loaded once every second sample.

`timescale 1ns/100ps
`default_nettype none

module dac_packer
    import qam_duc_pkg::*;
(
    input  wire logic  clk_341m,
    input  wire logic  rst_duc,
    input  samp_beat_t rot,
    input  wire logic  rot_valid,
    output dac_pair_t  dac_out,
    output logic       dac_valid
);

    logic slot_b;
    iq_t  held_a;

    always_ff @(posedge clk_341m or posedge rst_duc)
    begin
        if (rst_duc)
        begin
            slot_b    <= 1'b0;
            dac_valid <= 1'b0;
        end
        else
        begin
            dac_valid <= rot_valid & slot_b;
            if (rot_valid)
                slot_b <= ~slot_b;
        end
    end

    always_ff @(posedge clk_341m)
    begin
        if (rot_valid && !slot_b)
            held_a <= rot.iq;
        if (rot_valid && slot_b)
        begin
            dac_out.a <= held_a;
            dac_out.b <= rot.iq;
        end
    end

    // Pairs need two samples, so loads are never back to back.
    a_no_double_load: assert property (
        @(posedge clk_341m) disable iff (rst_duc) dac_valid |=> !dac_valid
    );

endmodule

`default_nettype wire

// File: verilog/mixer_stage.sv
// Baseband mixer reduced to quarter-turn rotations.
// One phase accumulator per channel selects the rotation quadrant.

`timescale 1ns/100ps
`default_nettype none

module mixer_stage
    import qam_duc_pkg::*;
(
    input  wire logic  clk_341m,
    input  wire logic  rst_duc,
    input  samp_beat_t samp,
    input  wire logic  samp_valid,
    input  cfg_t       cfg,
    output samp_beat_t rot,
    output logic       rot_valid
);

    logic [NUM_CH-1:0][FREQ_W-1:0] phase;
    logic [1:0]                    quad;

    assign quad = phase[samp.ch][FREQ_W-1 -: 2];

    // Phase advances only when its own channel carries a sample.
    always_ff @(posedge clk_341m or posedge rst_duc)
    begin
        if (rst_duc)
        begin
            phase     <= '0;
            rot_valid <= 1'b0;
        end
        else
        begin
            rot_valid <= samp_valid;
            if (samp_valid)
                phase[samp.ch] <= phase[samp.ch] + cfg.freq[samp.ch];
        end
    end

    always_ff @(posedge clk_341m)
    begin
        if (samp_valid)
        begin
            rot.ch <= samp.ch;
            case (quad)
                2'd0:
                begin
                    rot.iq.i <= samp.iq.i;
                    rot.iq.q <= samp.iq.q;
                end
                2'd1:
                begin
                    rot.iq.i <= -samp.iq.q;
                    rot.iq.q <= samp.iq.i;
                end
                2'd2:
                begin
                    rot.iq.i <= -samp.iq.i;
                    rot.iq.q <= -samp.iq.q;
                end
                default:
                begin
                    rot.iq.i <= samp.iq.q;
                    rot.iq.q <= -samp.iq.i;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/qam_mapper.sv
// 16-QAM symbol mapper with per-channel gain.
// Beats of disabled channels are dropped here.

`timescale 1ns/100ps
`default_nettype none

module qam_mapper
    import qam_duc_pkg::*;
(
    input  wire logic clk_341m,
    input  wire logic rst_duc,
    input  sym_beat_t beat,
    input  wire logic beat_valid,
    input  cfg_t      cfg,
    output samp_beat_t samp,
    output logic      samp_valid
);

    logic signed [SAMP_W-1:0] lvl_i;
    logic signed [SAMP_W-1:0] lvl_q;
    logic signed [SAMP_W-1:0] gain_s;
    logic                     ch_on;

    // Gray coded levels.
    function automatic logic signed [SAMP_W-1:0] gray_level(input logic [1:0] bits);
        logic signed [SAMP_W-1:0] lvl;
        case (bits)
            2'b00:   lvl = -14'sd3;
            2'b01:   lvl = -14'sd1;
            2'b11:   lvl = 14'sd1;
            default: lvl = 14'sd3;
        endcase
        return lvl;
    endfunction

    assign lvl_i  = gray_level(beat.sym[3:2]);
    assign lvl_q  = gray_level(beat.sym[1:0]);
    assign gain_s = $signed({{(SAMP_W-GAIN_W){1'b0}}, cfg.gain[beat.ch]});
    assign ch_on  = cfg.ena[beat.ch];

    always_ff @(posedge clk_341m or posedge rst_duc)
    begin
        if (rst_duc)
            samp_valid <= 1'b0;
        else
            samp_valid <= beat_valid & ch_on;
    end

    // Largest product is 3 x 255, well inside the sample width.
    always_ff @(posedge clk_341m)
    begin
        if (beat_valid)
        begin
            samp.ch   <= beat.ch;
            samp.iq.i <= lvl_i * gain_s;
            samp.iq.q <= lvl_q * gain_s;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sym_intake.sv
// Four-phase req/ack symbol receiver.
// Captures one symbol beat per completed transfer.

`timescale 1ns/100ps
`default_nettype none

module sym_intake
    import qam_duc_pkg::*;
(
    input  wire logic      clk_341m,
    input  wire logic      rst_duc,
    input  wire logic      sym_req,
    input  sym_beat_t      sym_in,
    output logic           sym_ack,
    output sym_beat_t      beat,
    output logic           beat_valid
);

    intake_state_e state;

    always_ff @(posedge clk_341m or posedge rst_duc)
    begin
        if (rst_duc)
        begin
            state      <= IDLE;
            beat_valid <= 1'b0;
        end
        else
        begin
            beat_valid <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (sym_req)
                    begin
                        state      <= ACK;
                        beat_valid <= 1'b1;
                    end
                end
                ACK:
                begin
                    state <= sym_req ? WAIT_LOW : IDLE;
                end
                WAIT_LOW:
                begin
                    if (!sym_req)
                        state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_341m)
    begin
        if (state == IDLE && sym_req)
            beat <= sym_in;
    end

    // Ack stays high until the source has dropped req.
    assign sym_ack = (state != IDLE);

    a_ack_under_req: assert property (
        @(posedge clk_341m) disable iff (rst_duc) $rose(sym_ack) |-> sym_req
    );

endmodule

`default_nettype wire

// File: verilog/cfg_regs.sv
// Host register file for the modulator.
// Synchronizes the level write strobe and updates per-channel gain, frequency and enables.

`timescale 1ns/100ps
`default_nettype none

module cfg_regs
    import qam_duc_pkg::*;
(
    input  wire logic              clk_341m,
    input  wire logic              rst_duc,
    input  wire logic [ADDR_W-1:0] cfg_addr,
    input  wire logic [DATA_W-1:0] cfg_data,
    input  wire logic              cfg_write,
    output cfg_t                   cfg
);

    logic       write_s1;
    logic       write_s2;
    logic       write_s3;
    logic       wr_pulse;
    reg_group_e grp;
    logic [3:0] nib;

    function automatic reg_group_e decode_group(input logic [7:0] hi);
        reg_group_e g;
        case (hi)
            GRP_GAIN: g = GRP_GAIN;
            GRP_FREQ: g = GRP_FREQ;
            GRP_ENA:  g = GRP_ENA;
            default:  g = GRP_NONE;
        endcase
        return g;
    endfunction

    assign grp = decode_group(cfg_addr[ADDR_W-1:4]);
    assign nib = cfg_addr[3:0];

    // Strobe is sampled three deep; the pulse marks its rising edge.
    always_ff @(posedge clk_341m or posedge rst_duc)
    begin
        if (rst_duc)
        begin
            write_s1 <= 1'b0;
            write_s2 <= 1'b0;
            write_s3 <= 1'b0;
            wr_pulse <= 1'b0;
        end
        else
        begin
            write_s1 <= cfg_write;
            write_s2 <= write_s1;
            write_s3 <= write_s2;
            wr_pulse <= write_s2 & ~write_s3;
        end
    end

    always_ff @(posedge clk_341m or posedge rst_duc)
    begin
        if (rst_duc)
        begin
            cfg <= '0;
        end
        else if (wr_pulse)
        begin
            case (grp)
                GRP_GAIN:
                begin
                    if (nib < NUM_CH)
                        cfg.gain[nib[CH_W-1:0]] <= cfg_data[GAIN_W-1:0];
                end
                GRP_FREQ:
                begin
                    if (nib < NUM_CH)
                        cfg.freq[nib[CH_W-1:0]] <= cfg_data[FREQ_W-1:0];
                end
                GRP_ENA:
                begin
                    if (cfg_addr == ADDR_ENA)
                        cfg.ena <= cfg_data[NUM_CH-1:0];
                end
                default:
                begin
                end
            endcase
        end
    end

    // A held strobe must still give a single write.
    a_single_write: assert property (
        @(posedge clk_341m) disable iff (rst_duc) wr_pulse |=> !wr_pulse
    );

endmodule

`default_nettype wire

// File: verilog/qam_duc_pkg.sv
// QAM baseband modulator shared definitions.
// Widths, host register map, state and opcode enums, pipeline beat structs.

`default_nettype none

package qam_duc_pkg;

    localparam int NUM_CH = 8;
    localparam int CH_W   = 3;
    localparam int SYM_W  = 4;
    localparam int GAIN_W = 8;
    localparam int FREQ_W = 10;
    localparam int SAMP_W = 14;
    localparam int ADDR_W = 12;
    localparam int DATA_W = 16;

    localparam logic [ADDR_W-1:0] ADDR_ENA = 12'h511;

    // Upper address byte selects the register group.
    typedef enum logic [7:0] {
        GRP_GAIN = 8'h41,
        GRP_ENA  = 8'h51,
        GRP_FREQ = 8'h52,
        GRP_NONE = 8'hff
    } reg_group_e;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_LOW
    } intake_state_e;

    typedef struct packed {
        logic [CH_W-1:0]  ch;
        logic [SYM_W-1:0] sym;
    } sym_beat_t;

    typedef struct packed {
        logic signed [SAMP_W-1:0] i;
        logic signed [SAMP_W-1:0] q;
    } iq_t;

    typedef struct packed {
        logic [CH_W-1:0] ch;
        iq_t             iq;
    } samp_beat_t;

    typedef struct packed {
        logic [NUM_CH-1:0]              ena;
        logic [NUM_CH-1:0][GAIN_W-1:0] gain;
        logic [NUM_CH-1:0][FREQ_W-1:0] freq;
    } cfg_t;

    typedef struct packed {
        iq_t a;
        iq_t b;
    } dac_pair_t;

endpackage

`default_nettype wire
